/* all.f */
hw/duty_pkg.sv
hw/meas_if.sv
hw/period_tracker.sv
hw/percent_divider.sv
hw/duty_stabilizer.sv
hw/duty_meter_top.sv
tb/clk_gen.sv
tb/duty_meter_sva.sv
tb/duty_meter_tb.sv

/* hw/duty_meter_top.sv */
`timescale 1ns/1ps
`default_nettype none

module duty_meter_top (
    input wire                          clk,
    input wire                          rst_n,
    input wire [duty_pkg::SAMPLE_W-1:0] wave_in,
    input wire [duty_pkg::SAMPLE_W-1:0] amplitude,
    output wire [duty_pkg::PCT_W-1:0]   duty,
    output wire                         duty_valid
);
    import duty_pkg::*;

    wire             pct_valid;
    wire [PCT_W-1:0] pct;

    meas_if meas ();

    period_tracker u_tracker (
        .clk       (clk),
        .rst_n     (rst_n),
        .wave_in   (wave_in),
        .amplitude (amplitude),
        .meas      (meas.tracker)
    );

    percent_divider u_divider (
        .clk       (clk),
        .rst_n     (rst_n),
        .meas      (meas.divider),
        .pct_valid (pct_valid),
        .pct       (pct)
    );

    duty_stabilizer u_stabilizer (
        .clk        (clk),
        .rst_n      (rst_n),
        .pct_valid  (pct_valid),
        .pct        (pct),
        .duty       (duty),
        .duty_valid (duty_valid)
    );

endmodule

`default_nettype wire

/* hw/duty_pkg.sv */
`default_nettype none

package duty_pkg;

    localparam int SAMPLE_W       = 8;
    localparam int CNT_W          = 10;
    localparam int PCT_W          = 7;
    localparam int THRESHOLD      = 4;
    localparam int STABLE_REPEATS = 4;
    localparam int CREDITS        = 2;

    // Derived widths.
    localparam int CRED_W = $clog2(CREDITS + 1);
    localparam int QPTR_W = $clog2(CREDITS);
    // high*100 stays below 2^(CNT_W+7).
    localparam int PROD_W = CNT_W + 7;
    localparam int STEP_W = $clog2(PCT_W + 1);
    localparam int RUN_W  = $clog2(STABLE_REPEATS + 1);

    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    // Period tracker states.
    localparam logic [1:0] ST_WAIT_LOW  = 2'd0;
    localparam logic [1:0] ST_WAIT_HIGH = 2'd1;
    localparam logic [1:0] ST_IN_HIGH   = 2'd2;
    localparam logic [1:0] ST_IN_LOW    = 2'd3;

endpackage

`default_nettype wire

/* hw/duty_stabilizer.sv */
`timescale 1ns/1ps
`default_nettype none

module duty_stabilizer (
    input wire                         clk,
    input wire                         rst_n,
    input wire                         pct_valid,
    input wire [duty_pkg::PCT_W-1:0]   pct,
    output logic [duty_pkg::PCT_W-1:0] duty,
    output logic                       duty_valid
);
    import duty_pkg::*;

    logic [PCT_W-1:0] last_pct;
    logic             primed;
    logic [RUN_W-1:0] run_cnt;
    logic [RUN_W-1:0] run_nxt;
    logic             repeat_hit;

    assign repeat_hit = primed && (pct == last_pct);

    // Run count saturates once the repeat target is reached.
    always_comb begin
        run_nxt = '0;
        if (repeat_hit) begin
            run_nxt = (run_cnt == RUN_W'(STABLE_REPEATS)) ? run_cnt : run_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pct_valid) begin
            last_pct <= pct;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            primed     <= 1'b0;
            run_cnt    <= '0;
            duty       <= '0;
            duty_valid <= 1'b0;
        end else if (pct_valid) begin
            primed  <= 1'b1;
            run_cnt <= run_nxt;
            // Fifth equal result in a row.
            if (run_nxt >= RUN_W'(STABLE_REPEATS)) begin
                duty       <= pct;
                duty_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/meas_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface meas_if;
    import duty_pkg::*;

    logic             rec_valid;
    logic [CNT_W-1:0] high_cnt;
    logic [CNT_W-1:0] total_cnt;
    logic             credit_return;

    modport tracker (
        output rec_valid,
        output high_cnt,
        output total_cnt,
        input  credit_return
    );

    modport divider (
        input  rec_valid,
        input  high_cnt,
        input  total_cnt,
        output credit_return
    );

endinterface

`default_nettype wire

/* hw/percent_divider.sv */
`timescale 1ns/1ps
`default_nettype none

module percent_divider (
    input wire                           clk,
    input wire                           rst_n,
    meas_if.divider                      meas,
    output logic                         pct_valid,
    output logic [duty_pkg::PCT_W-1:0]   pct
);
    import duty_pkg::*;

    logic [CNT_W-1:0]  q_high  [CREDITS];
    logic [CNT_W-1:0]  q_total [CREDITS];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [CRED_W-1:0] q_count;

    logic              busy;
    logic [STEP_W-1:0] step;
    logic [PROD_W-1:0] rem;
    logic [PROD_W-1:0] den;
    logic [PCT_W-1:0]  quo;
    logic [PROD_W-1:0] head_high;
    logic [PROD_W-1:0] scaled;
    logic              start;
    logic              finish;

    // high * 100 = high * (64 + 32 + 4).
    assign head_high = PROD_W'(q_high[rd_ptr]);
    assign scaled    = (head_high << 6) + (head_high << 5) + (head_high << 2);

    assign finish = busy && (step == STEP_W'(PCT_W));
    assign start  = (!busy || finish) && (q_count != '0);

    always_ff @(posedge clk) begin
        if (meas.rec_valid) begin
            q_high[wr_ptr]  <= meas.high_cnt;
            q_total[wr_ptr] <= meas.total_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (meas.rec_valid) begin
                wr_ptr <= (wr_ptr == QPTR_W'(CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (start) begin
                rd_ptr <= (rd_ptr == QPTR_W'(CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (meas.rec_valid && !start) begin
                q_count <= q_count + 1'b1;
            end else if (!meas.rec_valid && start) begin
                q_count <= q_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy               <= 1'b0;
            step               <= '0;
            pct_valid          <= 1'b0;
            meas.credit_return <= 1'b0;
        end else begin
            pct_valid          <= finish;
            meas.credit_return <= finish;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (finish) begin
                busy <= 1'b0;
            end else if (busy) begin
                step <= step + 1'b1;
            end
        end
    end

    // Restoring division, one quotient bit per cycle, MSB first.
    always_ff @(posedge clk) begin
        if (start) begin
            rem <= scaled;
            den <= PROD_W'(q_total[rd_ptr]) << (PCT_W - 1);
            quo <= '0;
        end else if (busy && !finish) begin
            if (rem >= den) begin
                rem <= rem - den;
                quo <= {quo[PCT_W-2:0], 1'b1};
            end else begin
                quo <= {quo[PCT_W-2:0], 1'b0};
            end
            den <= den >> 1;
        end
        if (finish) begin
            pct <= quo;
        end
    end

endmodule

`default_nettype wire

/* hw/period_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module period_tracker (
    input wire                          clk,
    input wire                          rst_n,
    input wire [duty_pkg::SAMPLE_W-1:0] wave_in,
    input wire [duty_pkg::SAMPLE_W-1:0] amplitude,
    meas_if.tracker                     meas
);
    import duty_pkg::*;

    logic [SAMPLE_W-1:0] low_ref;
    logic [SAMPLE_W-1:0] hi_up;
    logic [SAMPLE_W-1:0] hi_dn;
    logic [SAMPLE_W-1:0] lo_up;
    logic [SAMPLE_W-1:0] lo_dn;
    logic                is_high;
    logic                is_low;

    logic [1:0]          state;
    logic [CNT_W-1:0]    run_high;
    logic [CNT_W-1:0]    run_total;
    logic                end_now;
    logic                period_end;
    logic [CRED_W-1:0]   credits;
    logic                spend;

    // Low reference is 256 - amplitude, wrapping in 8 bits.
    assign low_ref = ~amplitude + 1'b1;

    // Distances in both directions, modulo 256.
    assign hi_up = wave_in - amplitude;
    assign hi_dn = amplitude - wave_in;
    assign lo_up = wave_in - low_ref;
    assign lo_dn = low_ref - wave_in;

    assign is_high = (hi_up <= THRESHOLD) || (hi_dn <= THRESHOLD);
    assign is_low  = (lo_up <= THRESHOLD) || (lo_dn <= THRESHOLD);

    // A high sample after the low phase closes the period, unless it has saturated.
    assign end_now = (state == ST_IN_LOW) && is_high && (run_total != CNT_MAX);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_WAIT_LOW;
            run_high   <= '0;
            run_total  <= '0;
            period_end <= 1'b0;
        end else begin
            period_end <= end_now;
            case (state)
                ST_WAIT_LOW: begin
                    if (is_low) begin
                        state <= ST_WAIT_HIGH;
                    end
                end
                ST_WAIT_HIGH: begin
                    if (is_high) begin
                        state     <= ST_IN_HIGH;
                        run_high  <= CNT_W'(1);
                        run_total <= CNT_W'(1);
                    end
                end
                ST_IN_HIGH: begin
                    if (run_total == CNT_MAX) begin
                        state <= ST_WAIT_LOW;
                    end else begin
                        run_total <= run_total + 1'b1;
                        if (is_low) begin
                            state <= ST_IN_LOW;
                        end else begin
                            run_high <= run_high + 1'b1;
                        end
                    end
                end
                default: begin
                    if (run_total == CNT_MAX) begin
                        state <= ST_WAIT_LOW;
                    end else if (is_high) begin
                        // The ending sample opens the next period.
                        state     <= ST_IN_HIGH;
                        run_high  <= CNT_W'(1);
                        run_total <= CNT_W'(1);
                    end else begin
                        run_total <= run_total + 1'b1;
                    end
                end
            endcase
        end
    end

    // Record payload, held until the next period ends.
    always_ff @(posedge clk) begin
        if (end_now) begin
            meas.high_cnt  <= run_high;
            meas.total_cnt <= run_total;
        end
    end

    // Without a credit the record is dropped.
    assign spend = period_end && (credits != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits        <= CRED_W'(CREDITS);
            meas.rec_valid <= 1'b0;
        end else begin
            meas.rec_valid <= spend;
            if (spend && !meas.credit_return) begin
                credits <= credits - 1'b1;
            end else if (!spend && meas.credit_return) begin
                credits <= credits + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module duty_meter_tb \
    -f all.f -o duty_meter_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/duty_meter_sim > sim.log 2>&1 \
    || echo "Simulator exited with an error status" >> sim.log
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || exit 1
exit 0

/* tb/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset released on the third rising edge.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb/duty_meter_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module duty_meter_sva (
    input wire                        clk,
    input wire                        rst_n,
    input wire [duty_pkg::CRED_W-1:0] credits,
    input wire                        rec_valid,
    input wire                        credit_return,
    input wire                        pct_valid,
    input wire [duty_pkg::PCT_W-1:0]  pct
);
    import duty_pkg::*;

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CRED_W'(CREDITS))
        else $error("credit count %0d above %0d", credits, CREDITS);

    // The credit is spent on the edge that raises rec_valid.
    record_has_credit: assert property (@(posedge clk) disable iff (!rst_n)
        rec_valid |-> $past(credits) != '0)
        else $error("record issued with no credit held");

    return_with_result: assert property (@(posedge clk) disable iff (!rst_n)
        pct_valid == credit_return)
        else $error("pct_valid %0b and credit_return %0b differ", pct_valid, credit_return);

    pct_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        pct_valid |-> pct <= PCT_W'(100))
        else $error("percentage %0d above 100", pct);

endmodule

// Tracker credits and divider results seen from the level that holds both.
bind duty_meter_top duty_meter_sva meter_checks (
    .clk           (clk),
    .rst_n         (rst_n),
    .credits       (u_tracker.credits),
    .rec_valid     (meas.rec_valid),
    .credit_return (meas.credit_return),
    .pct_valid     (pct_valid),
    .pct           (pct)
);

`default_nettype wire

/* tb/duty_meter_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module duty_meter_tb;
    import duty_pkg::*;

    localparam logic [SAMPLE_W-1:0] MID_LEVEL = 8'd128;
    localparam int DRAIN_LIMIT = 60;
    // Generated period lengths of tests 2 to 6.
    localparam int GEN_SAMPLES = 12 * 15 + 12 * 20 + (4 * 10 + 4 * 20) + 20 * 5 + 12 * 10;
    localparam int CYCLE_LIMIT = 2 * GEN_SAMPLES + 200;

    wire                 clk;
    wire                 rst_n;
    logic [SAMPLE_W-1:0] wave_in;
    logic [SAMPLE_W-1:0] amplitude;
    wire  [PCT_W-1:0]    duty;
    wire                 duty_valid;

    integer           seed;
    int               cycle_cnt = 0;
    int               err_cnt;
    int               test_cnt;
    int               fail_cnt;
    logic             test_bad;
    logic             check_req;
    logic [PCT_W-1:0] exp_duty;
    logic             exp_valid;

    clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    duty_meter_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .wave_in    (wave_in),
        .amplitude  (amplitude),
        .duty       (duty),
        .duty_valid (duty_valid)
    );

    function automatic int ref_duty(input int high_len, input int total_len);
        return (high_len * 100) / total_len;
    endfunction

    task automatic drive_sample(input logic [SAMPLE_W-1:0] amp,
                                input logic [SAMPLE_W-1:0] level, input logic noisy);
        int noise;
        noise = noisy ? $random(seed) % (THRESHOLD + 1) : 0;
        @(posedge clk);
        amplitude <= amp;
        wave_in   <= level + SAMPLE_W'(noise);
    endtask

    // High phase, low phase, then one mid-scale transition sample.
    task automatic run_periods(input int count, input int high_len, input int total_len,
                               input logic [SAMPLE_W-1:0] amp);
        logic [SAMPLE_W-1:0] low_level;
        low_level = SAMPLE_W'(256 - int'(amp));
        for (int p = 0; p < count; p++) begin
            for (int i = 0; i < high_len; i++) begin
                drive_sample(amp, amp, 1'b1);
            end
            for (int i = 0; i < total_len - high_len - 1; i++) begin
                drive_sample(amp, low_level, 1'b1);
            end
            drive_sample(amp, MID_LEVEL, 1'b0);
        end
    endtask

    // Hold mid scale until duty shows the expected value or the drain limit runs out.
    task automatic settle(input int exp_d, input logic exp_v);
        int n;
        n = 0;
        @(negedge clk);
        while ((duty_valid !== exp_v || duty !== PCT_W'(exp_d)) && n < DRAIN_LIMIT) begin
            @(posedge clk);
            wave_in <= MID_LEVEL;
            @(negedge clk);
            n++;
        end
    endtask

    task automatic request_check(input int exp_d, input logic exp_v);
        exp_duty  = PCT_W'(exp_d);
        exp_valid = exp_v;
        check_req = 1'b1;
        wait (!check_req);
    endtask

    task automatic end_test(input int id, input string name);
        test_cnt++;
        if (test_bad) begin
            fail_cnt++;
            $display("Test %0d %s: FAILED", id, name);
        end else begin
            $display("Test %0d %s: ok", id, name);
        end
        test_bad = 1'b0;
    endtask

    // Compare process, sampled at the falling edge.
    always begin
        wait (check_req);
        if (duty_valid !== exp_valid) begin
            $display("ERR t=%0t duty_valid: got %0b expected %0b", $time, duty_valid, exp_valid);
            err_cnt++;
            test_bad = 1'b1;
        end
        if (duty !== exp_duty) begin
            $display("ERR t=%0t duty: got %0d expected %0d", $time, duty, exp_duty);
            err_cnt++;
            test_bad = 1'b1;
        end
        check_req = 1'b0;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        seed      = 32'h3eb0_4007;
        wave_in   = MID_LEVEL;
        amplitude = 8'd100;
        err_cnt   = 0;
        test_cnt  = 0;
        fail_cnt  = 0;
        test_bad  = 1'b0;
        check_req = 1'b0;
        exp_duty  = '0;
        exp_valid = 1'b0;
        wait (rst_n === 1'b1);

        settle(0, 1'b0);
        request_check(0, 1'b0);
        end_test(1, "reset state");

        run_periods(12, 5, 15, 8'd100);
        settle(ref_duty(5, 15), 1'b1);
        request_check(ref_duty(5, 15), 1'b1);
        end_test(2, "steady 5/15");

        // Four new results so far, old value must hold.
        run_periods(5, 12, 20, 8'd100);
        settle(ref_duty(5, 15), 1'b1);
        request_check(ref_duty(5, 15), 1'b1);
        run_periods(7, 12, 20, 8'd100);
        settle(ref_duty(12, 20), 1'b1);
        request_check(ref_duty(12, 20), 1'b1);
        end_test(3, "switch to 12/20");

        for (int k = 0; k < 4; k++) begin
            run_periods(1, 4, 10, 8'd100);
            run_periods(1, 9, 20, 8'd100);
            settle(ref_duty(12, 20), 1'b1);
            request_check(ref_duty(12, 20), 1'b1);
        end
        end_test(4, "alternating ratios");

        run_periods(20, 3, 5, 8'd100);
        settle(ref_duty(3, 5), 1'b1);
        request_check(ref_duty(3, 5), 1'b1);
        end_test(5, "short periods 3/5");

        run_periods(12, 7, 10, 8'd200);
        settle(ref_duty(7, 10), 1'b1);
        request_check(ref_duty(7, 10), 1'b1);
        end_test(6, "amplitude 200, 7/10");

        $display("Tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
